//--- common/audio_fmt_pkg.sv
`default_nettype none

package audio_fmt_pkg;

  ////////////////////////////////////////
  // fixed-point formats
  ////////////////////////////////////////

  localparam int sample_w = 16;           // one audio word
  localparam int q_bits   = 14;           // Q2.14 coefficients
  localparam int sum_w    = sample_w + 3; // six terms cannot wrap

  // signed pcm sample
  typedef logic signed [sample_w-1:0] sample_t;

  // gain or pan, 16384 is unity
  typedef logic signed [sample_w-1:0] coef_t;

  // left/right accumulator
  typedef logic signed [sum_w-1:0] sum_t;

endpackage

`default_nettype wire

//--- common/mixer_cfg_pkg.sv
`default_nettype none

package mixer_cfg_pkg;

  localparam int nr_channels   = 4;
  localparam int nr_requesters = nr_channels + 2; // channels plus left and right
  localparam int req_id_w      = $clog2(nr_requesters);

  typedef logic [req_id_w-1:0] req_id_t;

  // output slots follow the channel slots
  localparam req_id_t left_req  = req_id_t'(nr_channels);
  localparam req_id_t right_req = req_id_t'(nr_channels + 1);

  ////////////////////////////////////////
  // frame sequencer
  ////////////////////////////////////////

  typedef enum logic [2:0] {idle, gain, pan, out_gain, emit} mix_state_t;

endpackage

`default_nettype wire

//--- hdl/nq_multiplier.sv
`default_nettype none
`timescale 1ns/1ns

module nq_multiplier (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     mul_valid,
  output logic                    mul_ready,
  input  wire audio_fmt_pkg::sample_t mul_multiplicand,
  input  wire audio_fmt_pkg::coef_t   mul_multiplier,
  output logic                    prod_valid,
  output audio_fmt_pkg::sample_t  prod,
  output logic                    prod_overflow
);

  logic                                        s1_valid;
  logic signed [2*audio_fmt_pkg::sample_w-1:0] full_r;   // full width product
  logic signed [2*audio_fmt_pkg::sample_w-1:0] shifted;
  logic                                        ovf;

  assign mul_ready = !s1_valid && !prod_valid; // one operand pair at a time

  // floor division by 2^q_bits
  assign shifted = full_r >>> audio_fmt_pkg::q_bits;

  // fits only if every bit above the sample sign equals it
  assign ovf = shifted[2*audio_fmt_pkg::sample_w-1:audio_fmt_pkg::sample_w-1] !=
               {(audio_fmt_pkg::sample_w+1){shifted[audio_fmt_pkg::sample_w-1]}};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid   <= 1'b0;
      prod_valid <= 1'b0;
    end else begin
      s1_valid   <= mul_valid && mul_ready;
      prod_valid <= s1_valid;
    end
  end

  // datapath
  always_ff @(posedge clk) begin
    if (mul_valid && mul_ready) begin
      full_r <= mul_multiplicand * mul_multiplier;
    end
    if (s1_valid) begin
      prod_overflow <= ovf;
      if (!ovf) begin
        prod <= shifted[audio_fmt_pkg::sample_w-1:0];
      end else if (shifted[2*audio_fmt_pkg::sample_w-1]) begin
        prod <= {1'b1, {(audio_fmt_pkg::sample_w-1){1'b0}}}; // negative full scale
      end else begin
        prod <= {1'b0, {(audio_fmt_pkg::sample_w-1){1'b1}}};
      end
    end
  end

endmodule

`default_nettype wire

//--- mixer/mul_arbiter.sv
`default_nettype none
`timescale 1ns/1ns

module mul_arbiter (
  input  wire                                     clk,
  input  wire                                     rst_n,
  // requesters
  input  wire  [mixer_cfg_pkg::nr_requesters-1:0] req_valid,
  output logic [mixer_cfg_pkg::nr_requesters-1:0] req_ready,
  input  wire audio_fmt_pkg::sample_t req_multiplicand [mixer_cfg_pkg::nr_requesters],
  input  wire audio_fmt_pkg::coef_t   req_multiplier   [mixer_cfg_pkg::nr_requesters],
  // shared multiplier
  output logic                                    mul_valid,
  input  wire                                     mul_ready,
  output audio_fmt_pkg::sample_t                  mul_multiplicand,
  output audio_fmt_pkg::coef_t                    mul_multiplier,
  input  wire                                     prod_valid,
  input  wire audio_fmt_pkg::sample_t             prod,
  input  wire                                     prod_overflow,
  // responses
  output logic [mixer_cfg_pkg::nr_requesters-1:0] rsp_valid,
  output audio_fmt_pkg::sample_t                  rsp_product,
  output logic                                    rsp_overflow
);

  logic                   busy;    // request in flight
  logic                   found;
  logic                   accept;
  mixer_cfg_pkg::req_id_t last_id; // round-robin pointer
  mixer_cfg_pkg::req_id_t pick;
  mixer_cfg_pkg::req_id_t cur_id;  // owner of the product in flight

  ////////////////////////////////////////
  // round-robin pick
  ////////////////////////////////////////

  always_comb begin
    int idx;
    found = 1'b0;
    pick  = last_id;
    for (int k = 1; k <= mixer_cfg_pkg::nr_requesters; k++) begin
      idx = (int'(last_id) + k) % mixer_cfg_pkg::nr_requesters;
      if (!found && req_valid[idx]) begin
        found = 1'b1;
        pick  = mixer_cfg_pkg::req_id_t'(idx);
      end
    end
  end

  assign mul_valid        = found && !busy;
  assign accept           = mul_valid && mul_ready;
  assign mul_multiplicand = req_multiplicand[pick];
  assign mul_multiplier   = req_multiplier[pick];

  always_comb begin
    req_ready = '0;
    if (accept) begin
      req_ready[pick] = 1'b1;
    end
  end

  ////////////////////////////////////////
  // grant and product return
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      last_id   <= mixer_cfg_pkg::req_id_t'(mixer_cfg_pkg::nr_requesters - 1);
      cur_id    <= '0;
      rsp_valid <= '0;
    end else begin
      rsp_valid <= '0;
      if (accept) begin
        busy    <= 1'b1;
        last_id <= pick;
        cur_id  <= pick;
      end
      if (prod_valid) begin
        rsp_valid[cur_id] <= 1'b1;
      end
      if (|rsp_valid) begin
        busy <= 1'b0; // free once the response is out
      end
    end
  end

  always_ff @(posedge clk) begin
    if (prod_valid) begin
      rsp_product  <= prod;
      rsp_overflow <= prod_overflow;
    end
  end

endmodule

`default_nettype wire

//--- mixer/mixer_core.sv
`default_nettype none
`timescale 1ns/1ns

module mixer_core (
  input  wire                                     clk,
  input  wire                                     rst_n,
  // frame in
  input  wire audio_fmt_pkg::sample_t channel_data [mixer_cfg_pkg::nr_channels],
  input  wire                                     channel_valid,
  output logic                                    channel_ready,
  // stereo out
  output audio_fmt_pkg::sample_t                  out_left,
  output audio_fmt_pkg::sample_t                  out_right,
  output logic                                    out_valid,
  input  wire                                     out_ready,
  // levels
  input  wire audio_fmt_pkg::coef_t   channel_gain [mixer_cfg_pkg::nr_channels],
  input  wire audio_fmt_pkg::coef_t   channel_pan  [mixer_cfg_pkg::nr_channels],
  input  wire audio_fmt_pkg::coef_t               output_gain,
  // status
  output logic [mixer_cfg_pkg::nr_channels-1:0]   channel_clip,
  output logic                                    out_clip,
  // multiply requests
  output logic [mixer_cfg_pkg::nr_requesters-1:0] req_valid,
  input  wire  [mixer_cfg_pkg::nr_requesters-1:0] req_ready,
  output audio_fmt_pkg::sample_t req_multiplicand [mixer_cfg_pkg::nr_requesters],
  output audio_fmt_pkg::coef_t   req_multiplier   [mixer_cfg_pkg::nr_requesters],
  input  wire  [mixer_cfg_pkg::nr_requesters-1:0] rsp_valid,
  input  wire audio_fmt_pkg::sample_t             rsp_product,
  input  wire                                     rsp_overflow
);

  localparam int nc = mixer_cfg_pkg::nr_channels;
  localparam int sw = audio_fmt_pkg::sample_w;

  mixer_cfg_pkg::mix_state_t state;

  logic [mixer_cfg_pkg::nr_requesters-1:0] pending;  // responses still due
  logic [nc-1:0]                           clip_acc;
  logic                                    out_clip_acc;
  audio_fmt_pkg::sample_t                  g [nc];   // gained channel values
  audio_fmt_pkg::sum_t                     sum_l;
  audio_fmt_pkg::sum_t                     sum_r;
  audio_fmt_pkg::sample_t                  sat_l;
  audio_fmt_pkg::sample_t                  sat_r;
  logic                                    clip_l;
  logic                                    clip_r;
  logic                                    take;
  logic                                    gain_done;
  logic                                    pan_done;
  logic                                    og_done;

  function automatic audio_fmt_pkg::sample_t saturate(input audio_fmt_pkg::sum_t v);
    if (v[audio_fmt_pkg::sum_w-1:sw-1] == {(audio_fmt_pkg::sum_w-sw+1){v[sw-1]}}) begin
      return v[sw-1:0];
    end
    return v[audio_fmt_pkg::sum_w-1] ? {1'b1, {(sw-1){1'b0}}} : {1'b0, {(sw-1){1'b1}}};
  endfunction

  assign sat_l  = saturate(sum_l);
  assign sat_r  = saturate(sum_r);
  assign clip_l = audio_fmt_pkg::sum_t'(sat_l) != sum_l;
  assign clip_r = audio_fmt_pkg::sum_t'(sat_r) != sum_r;

  assign channel_ready = state == mixer_cfg_pkg::idle;
  assign take          = channel_ready && channel_valid;
  assign gain_done     = state == mixer_cfg_pkg::gain && pending == '0;
  assign pan_done      = state == mixer_cfg_pkg::pan && pending == '0;
  assign og_done       = state == mixer_cfg_pkg::out_gain && pending == '0;

  ////////////////////////////////////////
  // sequencer
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= mixer_cfg_pkg::idle;
      req_valid    <= '0;
      pending      <= '0;
      clip_acc     <= '0;
      out_clip_acc <= 1'b0;
      out_valid    <= 1'b0;
      channel_clip <= '0;
      out_clip     <= 1'b0;
    end else begin
      req_valid <= req_valid & ~req_ready; // drop once transferred
      pending   <= pending & ~rsp_valid;
      if (state == mixer_cfg_pkg::gain) begin
        clip_acc <= clip_acc | (rsp_valid[nc-1:0] & {nc{rsp_overflow}});
      end
      if (state == mixer_cfg_pkg::out_gain && (rsp_valid[mixer_cfg_pkg::left_req] ||
                                               rsp_valid[mixer_cfg_pkg::right_req])) begin
        out_clip_acc <= out_clip_acc | rsp_overflow;
      end

      if (take) begin
        state              <= mixer_cfg_pkg::gain;
        req_valid[nc-1:0]  <= '1;
        pending[nc-1:0]    <= '1;
        clip_acc           <= '0;
      end
      if (gain_done) begin
        state             <= mixer_cfg_pkg::pan;
        req_valid[nc-1:0] <= '1;
        pending[nc-1:0]   <= '1;
      end
      if (pan_done) begin
        state        <= mixer_cfg_pkg::out_gain;
        out_clip_acc <= clip_l | clip_r; // bus clipped before output gain
        req_valid[mixer_cfg_pkg::left_req]  <= 1'b1;
        req_valid[mixer_cfg_pkg::right_req] <= 1'b1;
        pending[mixer_cfg_pkg::left_req]    <= 1'b1;
        pending[mixer_cfg_pkg::right_req]   <= 1'b1;
      end
      if (og_done) begin
        state        <= mixer_cfg_pkg::emit;
        out_valid    <= 1'b1;
        channel_clip <= clip_acc;
        out_clip     <= out_clip_acc;
      end
      if (state == mixer_cfg_pkg::emit && out_ready) begin
        state     <= mixer_cfg_pkg::idle;
        out_valid <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // operands, sums and results
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    for (int i = 0; i < nc; i++) begin
      if (take) begin
        req_multiplicand[i] <= channel_data[i];
        req_multiplier[i]   <= channel_gain[i];
      end
      if (gain_done) begin
        req_multiplicand[i] <= g[i];
        req_multiplier[i]   <= channel_pan[i]; // pan sampled at stage start
      end
      if (rsp_valid[i] && state == mixer_cfg_pkg::gain) begin
        g[i] <= rsp_product;
      end
      if (rsp_valid[i] && state == mixer_cfg_pkg::pan) begin
        sum_l <= sum_l + audio_fmt_pkg::sum_t'(rsp_product);
        sum_r <= sum_r + audio_fmt_pkg::sum_t'(g[i]) - audio_fmt_pkg::sum_t'(rsp_product);
      end
    end
    if (gain_done) begin
      sum_l <= '0;
      sum_r <= '0;
    end
    if (pan_done) begin
      req_multiplicand[mixer_cfg_pkg::left_req]  <= sat_l;
      req_multiplicand[mixer_cfg_pkg::right_req] <= sat_r;
      req_multiplier[mixer_cfg_pkg::left_req]    <= output_gain;
      req_multiplier[mixer_cfg_pkg::right_req]   <= output_gain;
    end
    if (rsp_valid[mixer_cfg_pkg::left_req]) begin
      out_left <= rsp_product;
    end
    if (rsp_valid[mixer_cfg_pkg::right_req]) begin
      out_right <= rsp_product;
    end
  end

endmodule

`default_nettype wire

//--- hdl/audio_mixer_top.sv
`default_nettype none
`timescale 1ns/1ns

module audio_mixer_top (
  input  wire                                   clk,
  input  wire                                   rst_n,
  input  wire audio_fmt_pkg::sample_t channel_data [mixer_cfg_pkg::nr_channels],
  input  wire                                   channel_valid,
  output logic                                  channel_ready,
  output audio_fmt_pkg::sample_t                out_left,
  output audio_fmt_pkg::sample_t                out_right,
  output logic                                  out_valid,
  input  wire                                   out_ready,
  input  wire audio_fmt_pkg::coef_t   channel_gain [mixer_cfg_pkg::nr_channels],
  input  wire audio_fmt_pkg::coef_t   channel_pan  [mixer_cfg_pkg::nr_channels],
  input  wire audio_fmt_pkg::coef_t             output_gain,
  output logic [mixer_cfg_pkg::nr_channels-1:0] channel_clip,
  output logic                                  out_clip
);

  // core to arbiter
  logic [mixer_cfg_pkg::nr_requesters-1:0] req_valid;
  logic [mixer_cfg_pkg::nr_requesters-1:0] req_ready;
  audio_fmt_pkg::sample_t req_multiplicand [mixer_cfg_pkg::nr_requesters];
  audio_fmt_pkg::coef_t   req_multiplier   [mixer_cfg_pkg::nr_requesters];
  logic [mixer_cfg_pkg::nr_requesters-1:0] rsp_valid;
  audio_fmt_pkg::sample_t                  rsp_product;
  logic                                    rsp_overflow;

  // arbiter to multiplier
  logic                   mul_valid;
  logic                   mul_ready;
  audio_fmt_pkg::sample_t mul_multiplicand;
  audio_fmt_pkg::coef_t   mul_multiplier;
  logic                   prod_valid;
  audio_fmt_pkg::sample_t prod;
  logic                   prod_overflow;

  mixer_core mixer_core_i0 (
    .clk, .rst_n,
    .channel_data, .channel_valid, .channel_ready,
    .out_left, .out_right, .out_valid, .out_ready,
    .channel_gain, .channel_pan, .output_gain,
    .channel_clip, .out_clip,
    .req_valid, .req_ready, .req_multiplicand, .req_multiplier,
    .rsp_valid, .rsp_product, .rsp_overflow
  );

  mul_arbiter mul_arbiter_i0 (
    .clk, .rst_n,
    .req_valid, .req_ready, .req_multiplicand, .req_multiplier,
    .mul_valid, .mul_ready, .mul_multiplicand, .mul_multiplier,
    .prod_valid, .prod, .prod_overflow,
    .rsp_valid, .rsp_product, .rsp_overflow
  );

  nq_multiplier nq_multiplier_i0 (
    .clk, .rst_n,
    .mul_valid, .mul_ready, .mul_multiplicand, .mul_multiplier,
    .prod_valid, .prod, .prod_overflow
  );

endmodule

`default_nettype wire

//--- verif/audio_mixer_assertions.sv
`default_nettype none
`timescale 1ns/1ns

module audio_mixer_assertions (
  input wire                                    clk,
  input wire                                    rst_n,
  input wire                                    out_valid,
  input wire                                    out_ready,
  input wire audio_fmt_pkg::sample_t            out_left,
  input wire audio_fmt_pkg::sample_t            out_right,
  input wire                                    channel_ready,
  input wire [mixer_cfg_pkg::nr_requesters-1:0] rsp_valid
);

  // egress holds under back-pressure
  out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_left) && $stable(out_right))
    else $error("egress changed while out_ready was low");

  rsp_single: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(rsp_valid))
    else $error("more than one rsp_valid bit high");

  // idle right after reset
  reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> !out_valid && channel_ready)
    else $error("DUT not idle after reset");

endmodule

bind audio_mixer_top audio_mixer_assertions assertions_i0 (
  .clk, .rst_n, .out_valid, .out_ready, .out_left, .out_right, .channel_ready, .rsp_valid
);

`default_nettype wire

//--- verif/audio_mixer_tb.sv
`default_nettype none
`timescale 1ns/1ns

module audio_mixer_tb;

  localparam int nc       = mixer_cfg_pkg::nr_channels;
  localparam int wait_max = 2000; // cycles allowed per wait

  logic                   clk = 1'b0;
  logic                   rst_n;
  audio_fmt_pkg::sample_t channel_data [nc];
  logic                   channel_valid;
  logic                   channel_ready;
  audio_fmt_pkg::sample_t out_left;
  audio_fmt_pkg::sample_t out_right;
  logic                   out_valid;
  logic                   out_ready;
  audio_fmt_pkg::coef_t   channel_gain [nc];
  audio_fmt_pkg::coef_t   channel_pan  [nc];
  audio_fmt_pkg::coef_t   output_gain;
  logic [nc-1:0]          channel_clip;
  logic                   out_clip;

  // next frame, copied onto the ports once the DUT is idle
  audio_fmt_pkg::sample_t stim_data [nc];
  audio_fmt_pkg::coef_t   stim_gain [nc];
  audio_fmt_pkg::coef_t   stim_pan  [nc];
  audio_fmt_pkg::coef_t   stim_og;

  int exp_left  [$];
  int exp_right [$];
  int exp_cclip [$];
  int exp_oclip [$];

  int seed           = 32'h0e3e_db43;
  int ready_seed     = 32'h0e3e_db43; // out_ready draws its own sequence
  bit stall_out      = 1'b0;
  int mismatches     = 0;
  int other_failures = 0;
  int frames_sent    = 0;
  int frames_seen    = 0;

  audio_mixer_top UUT (
    .clk, .rst_n,
    .channel_data, .channel_valid, .channel_ready,
    .out_left, .out_right, .out_valid, .out_ready,
    .channel_gain, .channel_pan, .output_gain,
    .channel_clip, .out_clip
  );

  always #10 clk = ~clk;

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic int sat16(input longint v, output bit ovf);
    ovf = 1'b1;
    if (v > 32767) return 32767;
    if (v < -32768) return -32768;
    ovf = 1'b0;
    return int'(v);
  endfunction

  // floor(a * b / 2^q_bits), saturated
  function automatic int mul_q(input int a, input int b, output bit ovf);
    longint p;
    p = (longint'(a) * longint'(b)) >>> audio_fmt_pkg::q_bits;
    return sat16(p, ovf);
  endfunction

  function automatic void mix_reference(
    input  audio_fmt_pkg::sample_t x  [nc],
    input  audio_fmt_pkg::coef_t   gn [nc],
    input  audio_fmt_pkg::coef_t   pn [nc],
    input  audio_fmt_pkg::coef_t   og,
    output int                     l,
    output int                     r,
    output logic [nc-1:0]          cclip,
    output bit                     oclip
  );
    int     g;
    int     p;
    int     l16;
    int     r16;
    longint sl;
    longint sr;
    bit     f;
    sl    = 0;
    sr    = 0;
    cclip = '0;
    for (int i = 0; i < nc; i++) begin
      g        = mul_q(int'(x[i]), int'(gn[i]), f);
      cclip[i] = f;
      p        = mul_q(g, int'(pn[i]), f); // pan flag not reported
      sl      += p;
      sr      += g - p;
    end
    l16   = sat16(sl, f);
    oclip = f;
    r16   = sat16(sr, f);
    oclip = oclip | f;
    l     = mul_q(l16, int'(og), f);
    oclip = oclip | f;
    r     = mul_q(r16, int'(og), f);
    oclip = oclip | f;
  endfunction

  ////////////////////////////////////////
  // checking and run control
  ////////////////////////////////////////

  task automatic check_value(input string what, input logic signed [31:0] got,
                             input logic signed [31:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("[FAIL] %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("errors: %0d mismatches, %0d other failures, %0d of %0d frames seen",
             mismatches, other_failures, frames_seen, frames_sent);
    if (mismatches == 0 && other_failures == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  task automatic give_up(input string what);
    other_failures++;
    $display("timeout at %0t: %s", $time, what);
    finish_run();
  endtask

  task automatic wait_ready(input string what);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!channel_ready) begin
      cycles++;
      if (cycles > wait_max) give_up(what);
      @(negedge clk);
    end
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (exp_left.size() != 0) begin
      @(negedge clk);
      cycles++;
      if (cycles > wait_max) give_up("expected output frames never arrived");
    end
  endtask

  task automatic send_frame();
    int            l;
    int            r;
    logic [nc-1:0] cc;
    bit            oc;
    mix_reference(stim_data, stim_gain, stim_pan, stim_og, l, r, cc, oc);
    wait_ready("DUT never went back to idle");
    @(posedge clk);
    #1;
    channel_data  = stim_data; // levels held until the frame is out
    channel_gain  = stim_gain;
    channel_pan   = stim_pan;
    output_gain   = stim_og;
    channel_valid = 1'b1;
    exp_left.push_back(l);
    exp_right.push_back(r);
    exp_cclip.push_back(int'(cc));
    exp_oclip.push_back(int'(oc));
    frames_sent++;
    wait_ready("frame was not accepted");
    @(posedge clk);
    #1;
    channel_valid = 1'b0;
  endtask

  task automatic random_levels();
    for (int i = 0; i < nc; i++) begin
      stim_data[i] = audio_fmt_pkg::sample_t'($random(seed));
      stim_gain[i] = audio_fmt_pkg::coef_t'($random(seed) & 32'h7fff); // 0 to 2.0
      stim_pan[i]  = audio_fmt_pkg::coef_t'($random(seed) & 32'h3fff);
    end
    stim_og = audio_fmt_pkg::coef_t'($random(seed) & 32'h7fff);
  endtask

  task automatic flat_levels(input int data, input int gain, input int pan);
    for (int i = 0; i < nc; i++) begin
      stim_data[i] = audio_fmt_pkg::sample_t'(data);
      stim_gain[i] = audio_fmt_pkg::coef_t'(gain);
      stim_pan[i]  = audio_fmt_pkg::coef_t'(pan);
    end
    stim_og = audio_fmt_pkg::coef_t'(16384);
  endtask

  // output sink with optional stalls
  always begin
    @(posedge clk);
    #1;
    out_ready = stall_out ? (($random(ready_seed) & 3) != 0) : 1'b1;
  end

  // compare every output transfer with the next expected frame
  always @(negedge clk) begin
    if (rst_n && out_valid) begin
      check_value("channel_ready while output waits", channel_ready, 0);
      if (out_ready && exp_left.size() == 0) begin
        other_failures++;
        $display("output frame at %0t with no frame pending", $time);
      end else if (out_ready) begin
        check_value("out_left", out_left, exp_left.pop_front());
        check_value("out_right", out_right, exp_right.pop_front());
        check_value("channel_clip", channel_clip, exp_cclip.pop_front());
        check_value("out_clip", out_clip, exp_oclip.pop_front());
        frames_seen++;
      end
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial begin
    rst_n         = 1'b0;
    channel_valid = 1'b0;
    out_ready     = 1'b1;
    flat_levels(0, 0, 0);
    channel_data  = stim_data;
    channel_gain  = stim_gain;
    channel_pan   = stim_pan;
    output_gain   = stim_og;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    @(negedge clk);
    check_value("channel_ready after reset", channel_ready, 1);
    check_value("out_valid after reset", out_valid, 0);

    flat_levels(0, 16384, 8192); // unity gain, centre pan
    stim_data[0] = 16'sd1000;
    stim_data[1] = -16'sd2500;
    stim_data[2] = 16'sd7000;
    stim_data[3] = 16'sd12000;
    send_frame();

    repeat (20) begin
      random_levels();
      send_frame();
    end

    flat_levels(1200, 16384, 8192);
    stim_data[2] = 16'sd32767; // overdriven channel
    stim_gain[2] = 16'sd32767;
    send_frame();

    flat_levels(32767, 16384, 16384); // all hard left
    send_frame();

    stall_out = 1'b1;
    repeat (12) begin
      random_levels();
      send_frame();
    end

    wait_drained();
    finish_run();
  end

endmodule

`default_nettype wire

//--- audio_mixer_top.f
common/audio_fmt_pkg.sv
common/mixer_cfg_pkg.sv
hdl/nq_multiplier.sv
mixer/mul_arbiter.sv
mixer/mixer_core.sv
hdl/audio_mixer_top.sv
verif/audio_mixer_assertions.sv
verif/audio_mixer_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the mixer testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module audio_mixer_tb -f audio_mixer_top.f -o audio_mixer_sim > build.log 2>&1 \
  && ./obj_dir/audio_mixer_sim > sim.log 2>&1 \
  || echo "build or simulation exited with an error, see build.log and sim.log"

grep -q "^Result: PASSED$" sim.log 2>/dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
